//--- sdramPkg.sv
package sdramPkg;

	// Data and address geometry of the 16-bit, 4-bank part
	localparam int DataWidth = 16;
	localparam int BeWidth = DataWidth / 8;
	localparam int BankWidth = 2;
	localparam int RowWidth = 12;
	localparam int ColWidth = 8;
	localparam int AddrWidth = BankWidth + RowWidth + ColWidth;

	typedef struct packed {
		logic [BankWidth-1:0] bank;
		logic [RowWidth-1:0] row;
		logic [ColWidth-1:0] col;
	} sdramAddrFields_s;

	// Same 22 bits, seen flat by the host and split by the sequencer
	typedef union packed {
		logic [AddrWidth-1:0] flat;
		sdramAddrFields_s f;
	} sdramAddr_u;

	// {csN, rasN, casN, weN}
	typedef enum logic [3:0] {
		ModeSet      = 4'b0000,
		Refresh      = 4'b0001,
		PrechargeAll = 4'b0010,
		Active       = 4'b0011,
		Write        = 4'b0100,
		Read         = 4'b0101,
		Nop          = 4'b1111
	} sdramCmd_e;

	// Fixed timing in clocks
	localparam int CasLatency = 3;
	localparam int TrcdCycles = 2;
	localparam int TrpCycles = 2;
	localparam int TrfcCycles = 5;

	localparam int InitRefreshes = 8;

	// A10 selects all banks on precharge, auto-precharge on read/write
	localparam int ApBit = 10;

	// CAS latency 3, sequential, burst length 1
	localparam logic [RowWidth-1:0] ModeRegValue = 12'h030;

endpackage

//--- sdramReqIf.sv
`timescale 1ns/100ps

interface sdramReqIf import sdramPkg::*; ();

	logic valid; // Held until done
	logic write; // Low means read
	sdramAddr_u addr;
	logic [DataWidth-1:0] wrData;
	logic [BeWidth-1:0] byteEn;
	logic done; // One-cycle completion pulse
	logic [DataWidth-1:0] rdData; // Valid with done on reads

	// Avalon front stage
	modport reqSrc (
		output valid, write, addr, wrData, byteEn,
		input done, rdData
	);

	// Command sequencer
	modport reqSink (
		input valid, write, addr, wrData, byteEn,
		output done
	);

	// DQ data path
	modport dataSide (
		input wrData, byteEn,
		output rdData
	);

endinterface

//--- avlSlaveStage.sv
`timescale 1ns/100ps

module avlSlaveStage import sdramPkg::*; (
	input logic sys_clk,
	input logic rstn,
	input logic [AddrWidth-1:0] address,
	input logic [BeWidth-1:0] byteEnable,
	input logic read,
	input logic write,
	input logic [DataWidth-1:0] writeData,
	output logic [DataWidth-1:0] readData,
	output logic waitRequest,
	sdramReqIf.reqSrc req
);

	logic take; // New command accepted this edge
	logic finish; // Transfer completes this cycle

	// Only sampled while no request is held, so the command the master
	// still presents in the done cycle is not taken a second time
	assign take = !req.valid && (read || write);
	assign finish = req.valid && req.done;

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			req.valid <= 1'b0;
		end else if (finish) begin
			req.valid <= 1'b0;
		end else if (take) begin
			req.valid <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			req.write <= write;
			req.addr.flat <= address;
			req.wrData <= writeData;
			req.byteEn <= byteEnable;
		end
	end

	// Master is held except in the single done cycle
	assign waitRequest = !finish;
	assign readData = req.rdData; // Captured word, valid with finish

endmodule

//--- sdramSequencer.sv
`timescale 1ns/100ps

module sdramSequencer import sdramPkg::*; #(
	parameter int InitCycles = 10000,
	parameter int RefInterval = 390
) (
	input logic sys_clk,
	input logic rstn,
	sdramReqIf.reqSink req,
	output logic csN,
	output logic rasN,
	output logic casN,
	output logic weN,
	output logic [BankWidth-1:0] ba,
	output logic [RowWidth-1:0] sdAddr,
	output logic wrStrobe,
	output logic rdStrobe,
	input logic rdCaptured
);

	localparam int InitW = $clog2(InitCycles);
	localparam int RefW = $clog2(RefInterval + 1);
	localparam int WaitW = $clog2(TrfcCycles);
	localparam int InitRefW = $clog2(InitRefreshes + 1);

	typedef enum logic [3:0] {
		sInitWait,    // Power-up wait
		sPrecharge,
		sPreWait,
		sInitRef,
		sInitRefWait,
		sModeSet,
		sIdle,
		sRefresh,
		sRefWait,
		sActive,
		sTrcd,
		sWrite,
		sWrRecover,   // Write recovery plus auto-precharge
		sWrDone,
		sRead,
		sRdWait       // Until the data path captures
	} state_e;

	state_e state;
	sdramCmd_e cmd;

	logic [InitW-1:0] initCnt;
	logic [RefW-1:0] refCnt;
	logic [WaitW-1:0] waitCnt;
	logic [InitRefW-1:0] initRefCnt;
	logic waitDone;
	logic refDue;

	assign waitDone = (waitCnt == '0);
	assign refDue = (refCnt == RefW'(RefInterval));

	// Power-up wait
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			initCnt <= '0;
		else if (state == sInitWait)
			initCnt <= initCnt + 1'b1;
	end

	// Refresh interval, saturates until serviced
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			refCnt <= '0;
		else if (state == sRefresh || state == sModeSet)
			refCnt <= '0;
		else if (!refDue)
			refCnt <= refCnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state <= sInitWait;
			waitCnt <= '0;
			initRefCnt <= '0;
		end else begin
			case (state)
				sInitWait:
					if (initCnt == InitW'(InitCycles - 1))
						state <= sPrecharge;
				sPrecharge: begin
					waitCnt <= WaitW'(TrpCycles - 1);
					state <= sPreWait;
				end
				sPreWait:
					if (waitDone)
						state <= sInitRef;
					else
						waitCnt <= waitCnt - 1'b1;
				sInitRef: begin
					initRefCnt <= initRefCnt + 1'b1;
					waitCnt <= WaitW'(TrfcCycles - 1);
					state <= sInitRefWait;
				end
				sInitRefWait:
					if (!waitDone)
						waitCnt <= waitCnt - 1'b1;
					else if (initRefCnt == InitRefW'(InitRefreshes))
						state <= sModeSet;
					else
						state <= sInitRef;
				sModeSet:
					state <= sIdle;
				sIdle:
					if (refDue) // Refresh beats a waiting request
						state <= sRefresh;
					else if (req.valid)
						state <= sActive;
				sRefresh: begin
					waitCnt <= WaitW'(TrfcCycles - 1);
					state <= sRefWait;
				end
				sRefWait:
					if (waitDone)
						state <= sIdle;
					else
						waitCnt <= waitCnt - 1'b1;
				sActive: begin
					waitCnt <= WaitW'(TrcdCycles - 2);
					state <= sTrcd;
				end
				sTrcd:
					if (!waitDone)
						waitCnt <= waitCnt - 1'b1;
					else if (req.write)
						state <= sWrite;
					else
						state <= sRead;
				sWrite: begin
					waitCnt <= WaitW'(TrpCycles - 1);
					state <= sWrRecover;
				end
				sWrRecover:
					if (waitDone)
						state <= sWrDone;
					else
						waitCnt <= waitCnt - 1'b1;
				sWrDone:
					state <= sIdle;
				sRead:
					state <= sRdWait;
				sRdWait:
					if (rdCaptured)
						state <= sIdle;
				default:
					state <= sIdle;
			endcase
		end
	end

	// Command, bank and address decode
	always_comb begin
		cmd = Nop;
		ba = '0;
		sdAddr = '0;
		case (state)
			sPrecharge: begin
				cmd = PrechargeAll;
				sdAddr[ApBit] = 1'b1; // All banks
			end
			sInitRef, sRefresh:
				cmd = Refresh;
			sModeSet: begin
				cmd = ModeSet;
				sdAddr = ModeRegValue;
			end
			sActive: begin
				cmd = Active;
				ba = req.addr.f.bank;
				sdAddr = req.addr.f.row;
			end
			sWrite, sRead: begin
				cmd = (state == sWrite) ? Write : Read;
				ba = req.addr.f.bank;
				sdAddr = {{(RowWidth - ColWidth){1'b0}}, req.addr.f.col};
				sdAddr[ApBit] = 1'b1; // Auto-precharge
			end
			default:
				cmd = Nop;
		endcase
	end

	assign {csN, rasN, casN, weN} = cmd;
	assign wrStrobe = (state == sWrite);
	assign rdStrobe = (state == sRead);
	assign req.done = (state == sWrDone) || (state == sRdWait && rdCaptured);

endmodule

//--- sdramDataPath.sv
`timescale 1ns/100ps

module sdramDataPath import sdramPkg::*; (
	input logic sys_clk,
	input logic rstn,
	sdramReqIf.dataSide data,
	input logic wrStrobe,
	input logic rdStrobe,
	output logic [BeWidth-1:0] dqm,
	output logic [DataWidth-1:0] dqOut,
	output logic dqOe,
	input logic [DataWidth-1:0] dqIn,
	output logic rdCaptured
);

	// Read strobes in flight, one bit per clock since the Read command
	logic [CasLatency-2:0] rdPipe;
	logic capture;

	assign capture = rdPipe[CasLatency-2]; // Next edge is the CL-th

	// Write data only during the Write command cycle
	assign dqOut = data.wrData;
	assign dqOe = wrStrobe;

	assign dqm = ~data.byteEn; // Masks are active high

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			rdPipe <= '0;
			rdCaptured <= 1'b0;
		end else begin
			rdPipe <= {rdPipe[CasLatency-3:0], rdStrobe};
			rdCaptured <= capture;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (capture)
			data.rdData <= dqIn;
	end

endmodule

//--- sdramTop.sv
`timescale 1ns/100ps

module sdramTop import sdramPkg::*; #(
	parameter int InitCycles = 10000,
	parameter int RefInterval = 390
) (
	input logic sys_clk,
	input logic rstn,
	// Avalon-MM slave
	input logic [AddrWidth-1:0] address,
	input logic [BeWidth-1:0] byteEnable,
	input logic read,
	input logic write,
	input logic [DataWidth-1:0] writeData,
	output logic [DataWidth-1:0] readData,
	output logic waitRequest,
	// SDRAM
	output logic csN,
	output logic rasN,
	output logic casN,
	output logic weN,
	output logic [BankWidth-1:0] ba,
	output logic [RowWidth-1:0] sdAddr,
	output logic [BeWidth-1:0] dqm,
	output logic [DataWidth-1:0] dqOut,
	output logic dqOe,
	input logic [DataWidth-1:0] dqIn
);

	sdramReqIf reqBus ();

	logic wrStrobe;
	logic rdStrobe;
	logic rdCaptured;

	avlSlaveStage uAvl (
		.sys_clk     (sys_clk),
		.rstn        (rstn),
		.address     (address),
		.byteEnable  (byteEnable),
		.read        (read),
		.write       (write),
		.writeData   (writeData),
		.readData    (readData),
		.waitRequest (waitRequest),
		.req         (reqBus.reqSrc)
	);

	sdramSequencer #(
		.InitCycles  (InitCycles),
		.RefInterval (RefInterval)
	) uSeq (
		.sys_clk    (sys_clk),
		.rstn       (rstn),
		.req        (reqBus.reqSink),
		.csN        (csN),
		.rasN       (rasN),
		.casN       (casN),
		.weN        (weN),
		.ba         (ba),
		.sdAddr     (sdAddr),
		.wrStrobe   (wrStrobe),
		.rdStrobe   (rdStrobe),
		.rdCaptured (rdCaptured)
	);

	sdramDataPath uData (
		.sys_clk    (sys_clk),
		.rstn       (rstn),
		.data       (reqBus.dataSide),
		.wrStrobe   (wrStrobe),
		.rdStrobe   (rdStrobe),
		.dqm        (dqm),
		.dqOut      (dqOut),
		.dqOe       (dqOe),
		.dqIn       (dqIn),
		.rdCaptured (rdCaptured)
	);

endmodule

//--- tbSdramModel.sv
`timescale 1ns/100ps

module tbSdramModel import sdramPkg::*; #(
	parameter int RefInterval = 390
) (
	input logic sys_clk,
	input logic rstn,
	input logic csN,
	input logic rasN,
	input logic casN,
	input logic weN,
	input logic [BankWidth-1:0] ba,
	input logic [RowWidth-1:0] sdAddr,
	input logic [BeWidth-1:0] dqm,
	input logic [DataWidth-1:0] dqOut,
	input logic dqOe,
	output logic [DataWidth-1:0] dqIn,
	output logic modelErr
);

	sdramCmd_e cmd;
	logic [DataWidth-1:0] mem [int]; // Sparse array of the written words
	logic [AddrWidth-1:0] key; // {bank, row, col} in the open row
	logic [DataWidth-1:0] keep; // Bytes masked by DQM
	logic [DataWidth-1:0] rdWord;
	logic rdSlot; // Read word goes on the bus at the next edge
	logic [1:0] phase; // 0 power-up, 1 init refreshes, 2 running
	int initRefs;
	int sinceRef; // Clocks since the last refresh or mode set
	logic rowOpen;
	logic [BankWidth-1:0] openBank;
	logic [RowWidth-1:0] openRow;

	assign cmd = sdramCmd_e'({csN, rasN, casN, weN});
	assign key = {openBank, openRow, sdAddr[ColWidth-1:0]};
	assign keep = {{8{dqm[1]}}, {8{dqm[0]}}};

	// Never-written words read back as a pattern of their address
	function automatic logic [DataWidth-1:0] stored(input logic [AddrWidth-1:0] k);
		if (mem.exists(int'(k)))
			return mem[int'(k)];
		return k[15:0] ^ {k[21:16], k[9:0]};
	endfunction

	task automatic flagError(input string what);
		$display("SDRAM model error at %0t ns: %s", $time, what);
		modelErr <= 1'b1;
	endtask

	always @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			phase <= 2'd0;
			initRefs <= 0;
			sinceRef <= 0;
			rowOpen <= 1'b0;
			rdWord <= '0;
			rdSlot <= 1'b0;
			dqIn <= '0;
			modelErr <= 1'b0;
		end else begin
			// Read word only in the CL capture cycle and its inverse around it
			dqIn <= rdSlot ? rdWord : ~rdWord;
			rdSlot <= 1'b0;
			if (phase == 2'd2)
				sinceRef <= sinceRef + 1;
			if (sinceRef > RefInterval + 20)
				flagError("no REFRESH within the refresh interval");
			case (cmd)
				Nop: ;
				PrechargeAll:
					if (phase != 2'd0)
						flagError("PRECHARGE ALL outside the power-up sequence");
					else
						phase <= 2'd1;
				Refresh:
					if (phase == 2'd1)
						initRefs <= initRefs + 1;
					else if (phase == 2'd2 && !rowOpen)
						sinceRef <= 0;
					else
						flagError("REFRESH before PRECHARGE ALL or with a row open");
				ModeSet:
					if (phase != 2'd1 || initRefs != InitRefreshes)
						flagError("MODE REGISTER SET not after exactly eight refreshes");
					else if (sdAddr != ModeRegValue)
						flagError("MODE REGISTER SET with a wrong mode value");
					else
						phase <= 2'd2;
				Active:
					if (phase != 2'd2 || rowOpen)
						flagError("ACTIVATE before init finished or with a row open");
					else begin
						rowOpen <= 1'b1;
						openBank <= ba;
						openRow <= sdAddr;
					end
				Read, Write:
					if (!rowOpen || ba != openBank || !sdAddr[ApBit])
						flagError("READ or WRITE without its open row or auto-precharge");
					else if (cmd == Write && !dqOe)
						flagError("WRITE without write data on the bus");
					else begin
						rowOpen <= 1'b0; // Auto-precharge closes the row
						if (cmd == Read) begin
							rdWord <= stored(key);
							dqIn <= ~stored(key); // Not valid yet in the next cycle
							rdSlot <= 1'b1;
						end else
							mem[int'(key)] = (stored(key) & keep) | (dqOut & ~keep);
					end
				default:
					flagError("unknown command on the bus");
			endcase
		end
	end

endmodule

//--- tbSdramTop.sv
`timescale 1ns/100ps

module tbSdramTop import sdramPkg::*; ();

	localparam int InitCycles = 200;
	localparam int RefInterval = 150;
	localparam int WatchdogCycles = InitCycles + 400 * 40; // Generous per-transfer budget

	logic sys_clk;
	logic rstn;
	logic [AddrWidth-1:0] address;
	logic [BeWidth-1:0] byteEnable;
	logic read;
	logic write;
	logic [DataWidth-1:0] writeData;
	logic [DataWidth-1:0] readData;
	logic waitRequest;
	logic csN;
	logic rasN;
	logic casN;
	logic weN;
	logic [BankWidth-1:0] ba;
	logic [RowWidth-1:0] sdAddr;
	logic [BeWidth-1:0] dqm;
	logic [DataWidth-1:0] dqOut;
	logic dqOe;
	logic [DataWidth-1:0] dqIn;
	logic modelErr;

	sdramCmd_e busCmd;
	sdramAddr_u curAddr; // Address of the transfer in flight
	logic [DataWidth-1:0] expWord;
	logic [DataWidth-1:0] shadow [int];
	logic [AddrWidth-1:0] written [$]; // Addresses safe to read back
	int seed;

	sdramTop #(.InitCycles(InitCycles), .RefInterval(RefInterval)) DUT (.*);
	tbSdramModel #(.RefInterval(RefInterval)) uMem (.*);

	assign busCmd = sdramCmd_e'({csN, rasN, casN, weN});

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// Enabled bytes replaced, the rest kept
	function automatic logic [DataWidth-1:0] refWord(input logic [DataWidth-1:0] old,
			input logic [DataWidth-1:0] d, input logic [BeWidth-1:0] be);
		logic [DataWidth-1:0] w;
		w = old;
		if (be[0])
			w[7:0] = d[7:0];
		if (be[1])
			w[15:8] = d[15:8];
		return w;
	endfunction

	// One Avalon transfer, held until waitRequest drops
	task automatic avlXfer(input logic wr, input logic [AddrWidth-1:0] a,
			input logic [BeWidth-1:0] be, input logic [DataWidth-1:0] d);
		@(posedge sys_clk);
		address <= a;
		byteEnable <= be;
		writeData <= d;
		write <= wr;
		read <= !wr;
		curAddr.flat <= a;
		if (wr)
			shadow[a] = refWord(shadow.exists(a) ? shadow[a] : '0, d, be);
		else
			expWord <= shadow[a];
		do
			@(negedge sys_clk);
		while (waitRequest);
		@(posedge sys_clk);
		read <= 1'b0;
		write <= 1'b0;
	endtask

	// Read data and command addresses against the expected values
	always @(negedge sys_clk) begin
		if (modelErr) begin
			$display("The SDRAM model saw an illegal command sequence");
			$display("TEST FAILED");
			$fatal(1);
		end else begin
			if (rstn && read && !waitRequest)
				checkVal("readData", readData, expWord);
			if (busCmd == Active) begin
				checkVal("ba", ba, curAddr.f.bank);
				checkVal("sdAddr", sdAddr, curAddr.f.row);
			end else if (busCmd == Read || busCmd == Write) begin
				checkVal("ba", ba, curAddr.f.bank);
				checkVal("sdAddr", sdAddr, {4'b0100, curAddr.f.col}); // A10 set
			end
		end
	end

	initial begin
		repeat (WatchdogCycles) @(posedge sys_clk);
		$display("Watchdog expired after %0d clocks, a transfer never finished", WatchdogCycles);
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		logic [31:0] r;
		logic [AddrWidth-1:0] a;
		logic [BeWidth-1:0] be;

		seed = 78748;
		rstn = 1'b0;
		address = '0;
		byteEnable = '0;
		read = 1'b0;
		write = 1'b0;
		writeData = '0;
		curAddr = '0;
		expWord = '0;
		repeat (8) @(posedge sys_clk);
		rstn <= 1'b1;
		@(negedge sys_clk);
		checkVal("waitRequest", waitRequest, 1'b1);
		checkVal("cmd", {csN, rasN, casN, weN}, Nop);
		checkVal("dqOe", dqOe, 1'b0);

		// Full word, then one byte lane at a time
		avlXfer(1'b1, 22'h1234C5, 2'b11, 16'hA55A);
		avlXfer(1'b0, 22'h1234C5, 2'b11, 16'h0000);
		avlXfer(1'b1, 22'h1234C5, 2'b01, 16'h3C7E);
		avlXfer(1'b0, 22'h1234C5, 2'b11, 16'h0000);
		avlXfer(1'b1, 22'h1234C5, 2'b10, 16'h9FE1);
		avlXfer(1'b0, 22'h1234C5, 2'b11, 16'h0000);

		repeat (3 * RefInterval) @(posedge sys_clk); // Only refreshes on the bus

		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			if (written.size() == 0 || r[0]) begin
				a = AddrWidth'($random(seed));
				be = 2'b11;
				if (written.size() != 0 && r[1]) begin
					a = written[r[15:4] % written.size()]; // Merge into a known word
					be = (r[3:2] == 2'b00) ? 2'b01 : r[3:2];
				end
				written.push_back(a);
				avlXfer(1'b1, a, be, r[31:16]);
			end else
				avlXfer(1'b0, written[r[15:4] % written.size()], 2'b11, 16'h0000);
		end

		repeat (20) @(posedge sys_clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- vlog.f
sdramPkg.sv
sdramReqIf.sv
avlSlaveStage.sv
sdramSequencer.sv
sdramDataPath.sv
sdramTop.sv
tbSdramModel.sv
tbSdramTop.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbSdramTop -f vlog.f -o simSdram
./obj_dir/simSdram 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
grep -q "TEST PASSED" sim.log
